//--- include/decode_settings.svh
// widths, queue sizing and machine CSR addresses; queue depth must be a power of two
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define DEC_XLEN 64    // data path width
`define DEC_ILEN 32    // no compressed instructions

`define DEC_QUEUE_DEPTH 16    // entries, power of two
`define DEC_QUEUE_AFULL 12    // upstream ready drops at this fill level

`define DEC_CSR_MSTATUS 12'h300
`define DEC_CSR_MTVEC   12'h305
`define DEC_CSR_MEPC    12'h341
`define DEC_CSR_MCAUSE  12'h342

`endif

//--- rtl/decode_pkg.sv
// shared decode types; op_t holds exactly 64 members, so adding one means widening it
`default_nettype none
`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`DEC_XLEN-1:0] xlen_t;    // register / pc word
    typedef logic [`DEC_ILEN-1:0] inst_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [11:0]          csr_addr_t;

    typedef enum logic [5:0] {
        op_illegal,    // also "no instruction"
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_slliw, op_srliw, op_sraiw, op_addiw,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_mul, op_div, op_divu, op_remu,
        op_mulw, op_divw, op_divuw, op_remw, op_remuw,
        op_csrrw, op_csrrs, op_ecall, op_mret, op_ebreak
    } op_t;

endpackage

`default_nettype wire

//--- rtl/inst_queue.sv
// sync FIFO, DEPTH must be a power of two; writes while full and reads while empty are dropped
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int WIDTH = 96,
    parameter int DEPTH = 16,
    parameter int AFULL = 12
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,        // drops every entry at the edge
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,      // head, valid while not empty
    output logic             almost_full,
    output logic             full,
    output logic             empty
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];    // payload only
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;          // occupancy
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full        = count == CW'(DEPTH);
    assign empty       = count == '0;
    assign almost_full = count >= CW'(AFULL);    // slack of DEPTH-AFULL for in-flight pairs
    assign rd_data     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CW'(do_wr) - CW'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage_reg.sv
// decode register fed from the queue or straight from the input; a pair arriving with flush is lost
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module decode_stage_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                branch_flush,
    input  logic                in_valid,
    input  decode_pkg::xlen_t   in_pc,
    input  decode_pkg::inst_t   in_inst,
    input  logic                out_ready,
    input  logic                stall,
    output logic                in_ready,
    output logic                held_valid,
    output decode_pkg::xlen_t   held_pc,
    output decode_pkg::inst_t   held_inst,
    output logic                out_valid,
    output decode_pkg::xlen_t   out_pc,
    output decode_pkg::inst_t   out_inst
);
    import decode_pkg::*;

    localparam int EW = `DEC_XLEN + `DEC_ILEN;    // {pc, inst}

    logic          advance;
    logic          bypass;
    logic          q_wr;
    logic [EW-1:0] q_head;
    logic          q_afull;
    logic          q_full;
    logic          q_empty;
    xlen_t         head_pc;
    inst_t         head_inst;

    assign advance = out_ready && !stall;
    assign bypass  = q_empty && advance;    // skip the queue, straight into the register
    assign q_wr    = in_valid && !bypass;
    assign {head_pc, head_inst} = q_head;

    inst_queue #(
        .WIDTH (EW),
        .DEPTH (`DEC_QUEUE_DEPTH),
        .AFULL (`DEC_QUEUE_AFULL)
    ) i_inst_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (branch_flush),
        .wr_en       (q_wr),
        .wr_data     ({in_pc, in_inst}),
        .rd_en       (advance),    // pop ignored when empty
        .rd_data     (q_head),
        .almost_full (q_afull),
        .full        (q_full),
        .empty       (q_empty)
    );

    assign in_ready = !q_afull;

    always_ff @(posedge clk) begin
        if (!rst_n || branch_flush) begin
            held_valid <= 1'b0;
        end else if (advance) begin
            held_valid <= !q_empty || in_valid;    // nothing waiting -> bubble
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            held_pc   <= q_empty ? in_pc : head_pc;    // queue head has priority, keeps order
            held_inst <= q_empty ? in_inst : head_inst;
        end
    end

    // hidden from execute while stalled, still visible to decode
    assign out_valid = held_valid && !stall;
    assign out_pc    = stall ? '0 : held_pc;
    assign out_inst  = stall ? '0 : held_inst;

endmodule

`default_nettype wire

//--- rtl/load_use_interlock.sv
// load-use hazard on the held instruction; x0 is not excluded, so a load to x0 also stalls
`timescale 1ns/1ps
`default_nettype none

module load_use_interlock (
    input  logic              held_valid,
    input  decode_pkg::inst_t held_inst,
    input  logic              ex_valid,
    input  decode_pkg::inst_t ex_inst,
    output logic              stall
);
    import decode_pkg::*;

    reg_idx_t   ex_rd;
    logic       ex_load;
    logic [6:0] held_opc;
    logic [2:0] held_f3;
    logic       rs1_hit;
    logic       rs2_hit;
    logic       rs2_used;

    assign ex_rd    = ex_inst[11:7];
    assign ex_load  = ex_inst[6:0] == 7'b0000011 && ex_inst[14:12] != 3'b111;    // lb..lwu
    assign held_opc = held_inst[6:0];
    assign held_f3  = held_inst[14:12];

    assign rs1_hit = ex_rd == held_inst[19:15];
    assign rs2_hit = ex_rd == held_inst[24:20];

    // rs2 only counts where it is a real register source
    assign rs2_used = (held_opc == 7'b1100011 && held_f3 != 3'b010 && held_f3 != 3'b011)
                   || held_opc == 7'b0110011    // reg-reg, incl. mul/div
                   || held_opc == 7'b0111011;   // word reg-reg

    assign stall = held_valid && ex_valid && ex_load && (rs1_hit || (rs2_used && rs2_hit));

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
// RV64IM subset plus csrrw, csrrs, ecall, mret and ebreak; anything else is op_illegal with wen low
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module inst_decoder (
    input  logic                 held_valid,
    input  decode_pkg::inst_t    held_inst,
    output decode_pkg::op_t      op,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rs1,
    output decode_pkg::reg_idx_t rs2,
    output logic                 wen,
    output decode_pkg::xlen_t    imm
);
    import decode_pkg::*;

    inst_t       inst;
    logic [16:0] key;    // {funct7, funct3, opcode}
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       imm_s;
    xlen_t       imm_b;

    assign inst = held_valid ? held_inst : '0;    // empty register decodes as illegal
    assign key  = {inst[31:25], inst[14:12], inst[6:0]};
    assign rd   = inst[11:7];
    assign rs1  = inst[19:15];
    assign rs2  = inst[24:20];

    assign imm_i = {{(`DEC_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`DEC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`DEC_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_s = {{(`DEC_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`DEC_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        casez (key)
            17'b???????_???_0110111: op = op_lui;
            17'b???????_???_0010111: op = op_auipc;
            17'b???????_???_1101111: op = op_jal;
            17'b???????_000_1100111: op = op_jalr;
            17'b???????_000_1100011: op = op_beq;
            17'b???????_001_1100011: op = op_bne;
            17'b???????_100_1100011: op = op_blt;
            17'b???????_101_1100011: op = op_bge;
            17'b???????_110_1100011: op = op_bltu;
            17'b???????_111_1100011: op = op_bgeu;
            17'b???????_000_0000011: op = op_lb;
            17'b???????_001_0000011: op = op_lh;
            17'b???????_010_0000011: op = op_lw;
            17'b???????_011_0000011: op = op_ld;
            17'b???????_100_0000011: op = op_lbu;
            17'b???????_101_0000011: op = op_lhu;
            17'b???????_110_0000011: op = op_lwu;
            17'b???????_000_0100011: op = op_sb;
            17'b???????_001_0100011: op = op_sh;
            17'b???????_010_0100011: op = op_sw;
            17'b???????_011_0100011: op = op_sd;
            17'b???????_000_0010011: op = op_addi;
            17'b???????_010_0010011: op = op_slti;
            17'b???????_011_0010011: op = op_sltiu;
            17'b???????_100_0010011: op = op_xori;
            17'b???????_110_0010011: op = op_ori;
            17'b???????_111_0010011: op = op_andi;
            17'b000000?_001_0010011: op = op_slli;    // 6-bit shamt, bit 25 free
            17'b000000?_101_0010011: op = op_srli;
            17'b010000?_101_0010011: op = op_srai;
            17'b0000000_001_0011011: op = op_slliw;
            17'b0000000_101_0011011: op = op_srliw;
            17'b0100000_101_0011011: op = op_sraiw;
            17'b???????_000_0011011: op = op_addiw;
            17'b0000000_000_0110011: op = op_add;
            17'b0100000_000_0110011: op = op_sub;
            17'b0000000_001_0110011: op = op_sll;
            17'b0000000_010_0110011: op = op_slt;
            17'b0000000_011_0110011: op = op_sltu;
            17'b0000000_100_0110011: op = op_xor;
            17'b0000000_101_0110011: op = op_srl;
            17'b0100000_101_0110011: op = op_sra;
            17'b0000000_110_0110011: op = op_or;
            17'b0000000_111_0110011: op = op_and;
            17'b0000000_000_0111011: op = op_addw;
            17'b0100000_000_0111011: op = op_subw;
            17'b0000000_001_0111011: op = op_sllw;
            17'b0000000_101_0111011: op = op_srlw;
            17'b0100000_101_0111011: op = op_sraw;
            17'b0000001_000_0110011: op = op_mul;
            17'b0000001_100_0110011: op = op_div;
            17'b0000001_101_0110011: op = op_divu;
            17'b0000001_111_0110011: op = op_remu;
            17'b0000001_000_0111011: op = op_mulw;
            17'b0000001_100_0111011: op = op_divw;
            17'b0000001_101_0111011: op = op_divuw;
            17'b0000001_110_0111011: op = op_remw;
            17'b0000001_111_0111011: op = op_remuw;
            17'b???????_001_1110011: op = op_csrrw;
            17'b???????_010_1110011: op = op_csrrs;
            17'b???????_000_1110011: begin
                case (inst)    // system ops need the whole word
                    32'h0000_0073: op = op_ecall;
                    32'h0010_0073: op = op_ebreak;
                    32'h3020_0073: op = op_mret;
                    default:       op = op_illegal;
                endcase
            end
            default:                 op = op_illegal;
        endcase
    end

    always_comb begin
        case (op)
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_sb, op_sh, op_sw, op_sd,
            op_ecall, op_mret, op_ebreak, op_illegal: wen = 1'b0;    // no rd write
            default:                                  wen = 1'b1;
        endcase
    end

    always_comb begin
        case (op)
            op_lui, op_auipc:                              imm = imm_u;
            op_jal:                                        imm = imm_j;
            op_sb, op_sh, op_sw, op_sd:                    imm = imm_s;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: imm = imm_b;
            default:                                       imm = imm_i;    // csr addr lives here too
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/operand_select.sv
// operand muxing; only mstatus, mtvec, mepc and mcause are readable, other CSRs read as zero
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module operand_select (
    input  decode_pkg::op_t   op,
    input  decode_pkg::xlen_t imm,
    input  decode_pkg::xlen_t rs1_data,
    input  decode_pkg::xlen_t rs2_data,
    input  decode_pkg::xlen_t mtvec,
    input  decode_pkg::xlen_t mepc,
    input  decode_pkg::xlen_t mcause,
    input  decode_pkg::xlen_t mstatus,
    output decode_pkg::xlen_t src_a,
    output decode_pkg::xlen_t src_b
);
    import decode_pkg::*;

    csr_addr_t csr_addr;
    xlen_t     csr_data;

    assign csr_addr = imm[11:0];    // I-type field of csrrw / csrrs
    assign src_a    = rs1_data;

    always_comb begin
        case (csr_addr)
            `DEC_CSR_MSTATUS: csr_data = mstatus;
            `DEC_CSR_MTVEC:   csr_data = mtvec;
            `DEC_CSR_MEPC:    csr_data = mepc;
            `DEC_CSR_MCAUSE:  csr_data = mcause;
            default:          csr_data = '0;
        endcase
    end

    always_comb begin
        case (op)
            op_csrrw, op_csrrs: src_b = csr_data;    // old csr value
            op_ecall:           src_b = mtvec;       // trap target
            op_mret:            src_b = mepc;        // return target
            default:            src_b = rs2_data;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_decode_stage.sv
// decode stage top; register file is external and must answer rs1/rs2 reads in the same cycle
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::xlen_t    in_pc,
    input  decode_pkg::inst_t    in_inst,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::xlen_t    out_pc,
    output decode_pkg::inst_t    out_inst,
    output decode_pkg::op_t      op,
    output decode_pkg::reg_idx_t rd,
    output logic                 wen,
    output decode_pkg::xlen_t    imm,
    output decode_pkg::xlen_t    src_a,
    output decode_pkg::xlen_t    src_b,
    output decode_pkg::reg_idx_t rs1_addr,
    output decode_pkg::reg_idx_t rs2_addr,
    input  decode_pkg::xlen_t    rs1_data,
    input  decode_pkg::xlen_t    rs2_data,
    input  decode_pkg::xlen_t    mtvec,
    input  decode_pkg::xlen_t    mepc,
    input  decode_pkg::xlen_t    mcause,
    input  decode_pkg::xlen_t    mstatus,
    input  logic                 ex_valid,
    input  decode_pkg::inst_t    ex_inst,
    input  logic                 branch_flush
);
    import decode_pkg::*;

    logic  held_valid;
    inst_t held_inst;
    logic  stall;

    decode_stage_reg i_decode_stage_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch_flush (branch_flush),
        .in_valid     (in_valid),
        .in_pc        (in_pc),
        .in_inst      (in_inst),
        .out_ready    (out_ready),
        .stall        (stall),
        .in_ready     (in_ready),
        .held_valid   (held_valid),
        .held_pc      (),           // pc leaves through out_pc only
        .held_inst    (held_inst),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_inst     (out_inst)
    );

    load_use_interlock i_load_use_interlock (
        .held_valid (held_valid),
        .held_inst  (held_inst),
        .ex_valid   (ex_valid),
        .ex_inst    (ex_inst),
        .stall      (stall)
    );

    inst_decoder i_inst_decoder (
        .held_valid (held_valid),
        .held_inst  (held_inst),
        .op         (op),
        .rd         (rd),
        .rs1        (rs1_addr),    // straight to the register file
        .rs2        (rs2_addr),
        .wen        (wen),
        .imm        (imm)
    );

    operand_select i_operand_select (
        .op       (op),
        .imm      (imm),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .mstatus  (mstatus),
        .src_a    (src_a),
        .src_b    (src_b)
    );

endmodule

`default_nettype wire

//--- verif/rv_decode_stage_chk.sv
// queue and stall properties, bound into every rv_decode_stage; inactive during reset
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic q_full,
    input wire logic q_wr,
    input wire logic stall,
    input wire logic out_valid,
    input wire logic branch_flush
);

    // upstream must respect in_ready, so a full queue never sees a write
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) q_full |-> !q_wr)
        else $error("queue written while full");

    a_stall_hides: assert property (@(posedge clk) disable iff (!rst_n) stall |-> !out_valid)
        else $error("out_valid high during stall");

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
                                     branch_flush |=> !out_valid)
        else $error("out_valid high right after flush");

endmodule

bind rv_decode_stage rv_decode_stage_chk i_rv_decode_stage_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .q_full       (i_decode_stage_reg.q_full),
    .q_wr         (i_decode_stage_reg.q_wr),
    .stall        (stall),
    .out_valid    (out_valid),
    .branch_flush (branch_flush)
);

`default_nettype wire

//--- verif/tb_rv_decode_stage.sv
// drives a fixed decode table through the stage with random out_ready, a load-use stall and a flush
`timescale 1ns/1ps
`default_nettype none
`include "decode_settings.svh"

module tb_rv_decode_stage;
    import decode_pkg::*;

    localparam int    NROWS = 21;
    localparam int    TMO   = 400;                     // cycles per wait
    localparam xlen_t RK    = 64'h0101_0101_0000_0011;  // regfile model: value = index * RK
    localparam xlen_t MTVEC = 64'h0000_0000_8000_0100;
    localparam xlen_t MEPC  = 64'h0000_0000_8000_2468;
    localparam xlen_t MCAUS = 64'h8000_0000_0000_000b;
    localparam xlen_t MSTAT = 64'h0000_0000_0000_1888;

    logic clk = 1'b0, rst_n = 1'b0, in_valid = 1'b0, out_ready = 1'b0;
    logic ex_valid = 1'b0, branch_flush = 1'b0;
    xlen_t in_pc = '0;
    inst_t in_inst = '0, ex_inst = '0;
    logic out_valid, in_ready, wen;
    xlen_t out_pc, imm, src_a, src_b;
    inst_t out_inst;
    op_t op;
    reg_idx_t rd, rs1_addr, rs2_addr;
    xlen_t rs1_data, rs2_data;

    inst_t t_inst [NROWS];    // stimulus table
    op_t   t_op   [NROWS];
    int    t_rd   [NROWS];
    bit    t_wen  [NROWS];
    xlen_t t_imm  [NROWS];
    bit    t_rs2  [NROWS];    // src_b from the regfile model
    xlen_t t_srcb [NROWS];    // fixed src_b otherwise

    int    sb_idx [$];        // scoreboard, in order
    xlen_t sb_pc  [$];
    int    errors = 0, others = 0, seq = 0, n;
    bit    rand_ready = 1'b0, fixed_ready = 1'b0;

    assign rs1_data = xlen_t'(rs1_addr) * RK;    // combinational regfile
    assign rs2_data = xlen_t'(rs2_addr) * RK;

    always #50 clk = ~clk;

    rv_decode_stage i_rv_decode_stage (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_inst(in_inst), .out_valid(out_valid), .out_ready(out_ready),
        .out_pc(out_pc), .out_inst(out_inst), .op(op), .rd(rd), .wen(wen), .imm(imm),
        .src_a(src_a), .src_b(src_b), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .mtvec(MTVEC), .mepc(MEPC),
        .mcause(MCAUS), .mstatus(MSTAT), .ex_valid(ex_valid), .ex_inst(ex_inst),
        .branch_flush(branch_flush)
    );

    // only driver of out_ready, 1 ns after the edge
    always @(posedge clk) begin
        #1;
        out_ready = rand_ready ? (($urandom % 4) != 0) : fixed_ready;
    end

    task automatic add_row(input int i, input inst_t ins, input op_t o, input int r, input bit w,
                           input xlen_t im, input bit use_rs2, input xlen_t sb);
        t_inst[i] = ins;
        t_op[i]   = o;
        t_rd[i]   = r;
        t_wen[i]  = w;
        t_imm[i]  = im;
        t_rs2[i]  = use_rs2;
        t_srcb[i] = sb;
    endtask

    task automatic check_val(input string name, input xlen_t exp, input xlen_t act);
        assert (exp == act) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // scoreboard compare at every transfer
    always @(posedge clk) begin
        int    i;
        xlen_t pc;
        string tn;
        if (rst_n && out_valid && out_ready) begin
            assert (sb_idx.size() != 0) else begin
                others++;
                $display("transfer with nothing expected, pc %h", out_pc);
            end
            if (sb_idx.size() != 0) begin
                i  = sb_idx.pop_front();
                pc = sb_pc.pop_front();
                tn = $sformatf("row%0d", i);
                check_val({tn, " pc"}, pc, out_pc);
                check_val({tn, " inst"}, xlen_t'(t_inst[i]), xlen_t'(out_inst));
                check_val({tn, " op"}, xlen_t'(t_op[i]), xlen_t'(op));
                check_val({tn, " rd"}, xlen_t'(t_rd[i]), xlen_t'(rd));
                check_val({tn, " wen"}, xlen_t'(t_wen[i]), xlen_t'(wen));
                check_val({tn, " imm"}, t_imm[i], imm);
                check_val({tn, " src_a"}, xlen_t'(t_inst[i][19:15]) * RK, src_a);
                check_val({tn, " src_b"}, t_rs2[i] ? xlen_t'(t_inst[i][24:20]) * RK : t_srcb[i],
                          src_b);
            end
        end
    end

    // called 1 ns after an edge, returns 1 ns after an edge
    task automatic send(input int i, input bit expected);
        int t;
        t = 0;
        while (!in_ready && t < TMO) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!in_ready) begin
            others++;
            $display("in_ready stayed low, row %0d never sent", i);
        end else begin
            in_valid = 1'b1;
            in_pc    = 64'h8000_0000 + xlen_t'(seq) * 4;
            in_inst  = t_inst[i];
            if (expected) begin
                sb_idx.push_back(i);
                sb_pc.push_back(in_pc);
            end
            seq++;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (sb_idx.size() != 0 && t < TMO) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (sb_idx.size() != 0) begin
            others++;
            $display("%0d expected instructions never came out", sb_idx.size());
        end
    endtask

    task automatic ready_mode(input bit rnd, input bit lvl);
        @(negedge clk);
        rand_ready  = rnd;
        fixed_ready = lvl;
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(68874));
        add_row(0, 32'h123452B7, op_lui, 5, 1, 64'h12345000, 1, 0);
        add_row(1, 32'hFFFFF317, op_auipc, 6, 1, 64'hFFFF_FFFF_FFFF_F000, 1, 0);
        add_row(2, 32'h008000EF, op_jal, 1, 1, 64'd8, 1, 0);
        add_row(3, 32'h00008067, op_jalr, 0, 1, 64'd0, 1, 0);
        add_row(4, 32'hFE208EE3, op_beq, 29, 0, -64'sd4, 1, 0);
        add_row(5, 32'h01013503, op_ld, 10, 1, 64'd16, 1, 0);
        add_row(6, 32'hFE313C23, op_sd, 24, 0, -64'sd8, 1, 0);
        add_row(7, 32'hFFF00393, op_addi, 7, 1, -64'sd1, 1, 0);
        add_row(8, 32'h4214D413, op_srai, 8, 1, 64'h421, 1, 0);
        add_row(9, 32'h0055859B, op_addiw, 11, 1, 64'd5, 1, 0);
        add_row(10, 32'h40E68633, op_sub, 12, 1, 64'h40E, 1, 0);
        add_row(11, 32'h402087BB, op_subw, 15, 1, 64'h402, 1, 0);
        add_row(12, 32'h03288833, op_mul, 16, 1, 64'h032, 1, 0);
        add_row(13, 32'h035A69BB, op_remw, 19, 1, 64'h035, 1, 0);
        add_row(14, 32'h305022F3, op_csrrs, 5, 1, 64'h305, 0, MTVEC);
        add_row(15, 32'h7C009373, op_csrrw, 6, 1, 64'h7C0, 0, 0);    // unknown csr
        add_row(16, 32'h34202073, op_csrrs, 0, 1, 64'h342, 0, MCAUS);
        add_row(17, 32'h00000073, op_ecall, 0, 0, 64'd0, 0, MTVEC);
        add_row(18, 32'h30200073, op_mret, 0, 0, 64'h302, 0, MEPC);
        add_row(19, 32'h00100073, op_ebreak, 0, 0, 64'd1, 1, 0);
        add_row(20, 32'hFFFFFFFF, op_illegal, 31, 0, -64'sd1, 1, 0);

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        // fill with execute blocked until ready drops at the threshold
        n = 0;
        while (in_ready && n < NROWS) begin
            send(n, 1'b1);
            n++;
        end
        check_val("afull count", `DEC_QUEUE_AFULL, n);
        ready_mode(1'b1, 1'b0);
        for (int i = n; i < NROWS; i++)
            send(i, 1'b1);
        wait_drain();

        // load-use: ld x2 in execute, held ld reads x2
        ready_mode(1'b0, 1'b1);
        ex_valid = 1'b1;
        ex_inst  = 32'h0002B103;
        send(5, 1'b1);
        repeat (5) begin
            assert (!out_valid) else begin
                others++;
                $display("out_valid high during a load-use stall");
            end
            @(posedge clk);
            #1;
        end
        ex_valid = 1'b0;
        wait_drain();

        // flush drops the held pair and everything queued behind it
        ex_valid = 1'b1;
        send(5, 1'b0);    // enters the register, then stalls behind the load
        for (int i = 0; i < 4; i++)
            send(i, 1'b0);
        branch_flush = 1'b1;
        @(posedge clk);
        #1;
        branch_flush = 1'b0;
        ex_valid     = 1'b0;
        ready_mode(1'b1, 1'b0);
        for (int i = 10; i < 14; i++)
            send(i, 1'b1);
        wait_drain();
        repeat (10) @(posedge clk);

        $display("errors: %0d value, %0d other", errors, others);
        if (errors == 0 && others == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/decode_pkg.sv
rtl/inst_queue.sv
rtl/decode_stage_reg.sv
rtl/load_use_interlock.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/rv_decode_stage.sv
verif/rv_decode_stage_chk.sv
verif/tb_rv_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_decode_stage -f all.f -o sim_tb &&
./obj_dir/sim_tb > sim.log 2>&1 ;
cat sim.log ;
grep -qx "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
